/* cache_bank.f */
cache_pkg.sv
cache_sp_ram.sv
cache_tag_stage.sv
cache_data_stage.sv
cache_rsp_stage.sv
cache_bank.sv
cache_bank_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the cache bank testbench with Verilator and run it

set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -f cache_bank.f \
    --top-module cache_bank_tb -Mdir obj_dir -o cache_bank_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/cache_bank_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
exit 0

/* cache_bank_tb.sv */
// ==========================================================
// Cache bank testbench
// Reference model with expected outputs queued per cycle,
// checked by concurrent assertions against the DUT
// ==========================================================
`timescale 1ns/1ps

module cache_bank_tb;
    import cache_pkg::*;

    localparam int latency   = 3;
    localparam int drain_max = 20;
    localparam int num_rand  = 400;

    typedef struct packed {
        logic         rsp_valid;
        cache_rsp_t   rsp;
        logic         check_data;
        logic         evict_valid;
        cache_evict_t evict;
        int           due;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    cache_req_t   req;
    logic         rsp_valid;
    cache_rsp_t   rsp;
    logic         evict_valid;
    cache_evict_t evict;

    // Expected outputs for the current cycle
    logic         exp_rsp_valid;
    cache_rsp_t   exp_rsp;
    logic         exp_check_data;
    logic         exp_evict_valid;
    cache_evict_t exp_evict;

    // Reference model state
    logic [tag_bits-1:0]     m_tag   [num_sets][num_ways];
    logic                    m_valid [num_sets][num_ways];
    logic                    m_dirty [num_sets][num_ways];
    line_t                   m_line  [num_sets][num_ways];
    logic [way_idx_bits-1:0] m_rr    [num_sets];

    expect_t     exp_q[$];
    int          cyc;
    int          errors;
    int          tests_failed;
    logic [31:0] rng_state;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    cache_bank i_cache_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .evict_valid (evict_valid),
        .evict       (evict)
    );

    task automatic report_mismatch(input string name, input logic [159:0] expected,
                                   input logic [159:0] actual);
        $display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, expected, actual);
        errors++;
    endtask

    rsp_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid == exp_rsp_valid)
        else report_mismatch("rsp_valid", 160'($sampled(exp_rsp_valid)),
                             160'($sampled(rsp_valid)));

    evict_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        evict_valid == exp_evict_valid)
        else report_mismatch("evict_valid", 160'($sampled(exp_evict_valid)),
                             160'($sampled(evict_valid)));

    rsp_hit_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_rsp_valid |-> rsp.hit == exp_rsp.hit)
        else report_mismatch("rsp.hit", 160'($sampled(exp_rsp.hit)),
                             160'($sampled(rsp.hit)));

    rsp_data_a: assert property (@(posedge clk) disable iff (!rst_n)
        (exp_rsp_valid && exp_check_data) |-> rsp.data == exp_rsp.data)
        else report_mismatch("rsp.data", 160'($sampled(exp_rsp.data)),
                             160'($sampled(rsp.data)));

    evict_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_evict_valid |-> evict == exp_evict)
        else report_mismatch("evict", 160'($sampled(exp_evict)), 160'($sampled(evict)));

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < words_per_line; i++) begin
            l[i] = next_rand();
        end
        return l;
    endfunction

    function automatic logic [addr_width-1:0] make_addr(input logic [tag_bits-1:0] tag,
                                                        input logic [set_sel_bits-1:0] set,
                                                        input logic [word_sel_bits-1:0] word);
        return {tag, set, word};
    endfunction

    // Applies one request to the model and returns what the bank should output
    task automatic model_apply(input cache_req_t r, output expect_t e);
        logic [set_sel_bits-1:0]  set;
        logic [tag_bits-1:0]      tag;
        logic [word_sel_bits-1:0] word;
        logic                     hit;
        int                       way;
        set  = r.addr[word_sel_bits +: set_sel_bits];
        tag  = r.addr[addr_width-1 -: tag_bits];
        word = r.addr[word_sel_bits-1:0];
        hit  = 1'b0;
        way  = 0;
        e    = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        case (r.op)
            op_read: begin
                e.rsp_valid  = 1'b1;
                e.check_data = 1'b1;
                e.rsp.hit    = hit;
                e.rsp.data   = hit ? m_line[set][way][word] : '0;
            end
            op_write: begin
                // Write data returned alongside a write is not defined by the bank
                e.rsp_valid = 1'b1;
                e.rsp.hit   = hit;
                if (hit) begin
                    for (int b = 0; b < word_bytes; b++) begin
                        if (r.byteen[b]) begin
                            m_line[set][way][word][8*b +: 8] = r.wdata[8*b +: 8];
                        end
                    end
                    m_dirty[set][way] = 1'b1;
                end
            end
            op_fill: begin
                if (!hit) begin
                    way       = int'(m_rr[set]);
                    m_rr[set] = m_rr[set] + 1'b1;
                end
                if (m_valid[set][way] && m_dirty[set][way]) begin
                    e.evict_valid     = 1'b1;
                    e.evict.line_addr = {m_tag[set][way], set};
                    e.evict.data      = m_line[set][way];
                end
                m_tag[set][way]   = tag;
                m_valid[set][way] = 1'b1;
                m_dirty[set][way] = 1'b0;
                m_line[set][way]  = r.fill_line;
            end
            default: begin
                e.rsp_valid  = 1'b1;
                e.check_data = 1'b1;
                e.rsp.hit    = hit;
                e.rsp.data   = hit ? m_line[set][way][word] : '0;
                if (hit && m_dirty[set][way]) begin
                    e.evict_valid     = 1'b1;
                    e.evict.line_addr = {m_tag[set][way], set};
                    e.evict.data      = m_line[set][way];
                    m_dirty[set][way] = 1'b0;
                end
            end
        endcase
    endtask

    // One clock edge: publish the outputs due now, then drive the next request
    task automatic tick(input logic v, input cache_req_t r);
        expect_t e;
        @(posedge clk);
        cyc++;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            exp_rsp_valid   <= e.rsp_valid;
            exp_rsp         <= e.rsp;
            exp_check_data  <= e.check_data;
            exp_evict_valid <= e.evict_valid;
            exp_evict       <= e.evict;
        end else begin
            exp_rsp_valid   <= 1'b0;
            exp_evict_valid <= 1'b0;
        end
        req_valid <= v;
        req       <= r;
        if (v) begin
            model_apply(r, e);
            // Sampled at the next edge, then three stages
            e.due = cyc + 1 + latency;
            exp_q.push_back(e);
        end
    endtask

    task automatic issue(input cache_op_e op, input logic [addr_width-1:0] addr,
                         input logic [word_width-1:0] wdata,
                         input logic [word_bytes-1:0] byteen, input line_t fill_line);
        cache_req_t r;
        r.op        = op;
        r.addr      = addr;
        r.wdata     = wdata;
        r.byteen    = byteen;
        r.fill_line = fill_line;
        tick(1'b1, r);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < drain_max) begin
            tick(1'b0, '0);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d expected outputs still pending after %0d cycles",
                     exp_q.size(), drain_max);
            errors++;
            exp_q.delete();
        end
        // The last expected values are checked at the following edge
        tick(1'b0, '0);
        // Assertion actions of that edge have run by the falling edge
        @(negedge clk);
    endtask

    task automatic end_test(input int num, input string name, input int errors_before);
        drain();
        if (errors == errors_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        int          e0;
        logic [31:0] rnd;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req             = '0;
        exp_rsp_valid   = 1'b0;
        exp_rsp         = '0;
        exp_check_data  = 1'b0;
        exp_evict_valid = 1'b0;
        exp_evict       = '0;
        cyc             = 0;
        errors          = 0;
        tests_failed    = 0;
        rng_state       = 32'd24217;
        for (int s = 0; s < num_sets; s++) begin
            m_rr[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_line[s][w]  = '0;
            end
        end
        repeat (3) tick(1'b0, '0);
        rst_n <= 1'b1;

        e0 = errors;
        for (int s = 0; s < num_sets; s++) begin
            issue(op_read, make_addr(10'h000, 4'(s), 2'd0), '0, '0, '0);
        end
        end_test(1, "reset state", e0);

        e0 = errors;
        issue(op_fill, make_addr(10'h012, 4'd3, 2'd0), '0, '0, rand_line());
        for (int w = 0; w < words_per_line; w++) begin
            issue(op_read, make_addr(10'h012, 4'd3, 2'(w)), '0, '0, '0);
        end
        issue(op_read, make_addr(10'h02a, 4'd3, 2'd1), '0, '0, '0);
        end_test(2, "fill and read", e0);

        e0 = errors;
        issue(op_write, make_addr(10'h012, 4'd3, 2'd0), next_rand(), 4'b0001, '0);
        issue(op_write, make_addr(10'h012, 4'd3, 2'd1), next_rand(), 4'b0110, '0);
        issue(op_write, make_addr(10'h012, 4'd3, 2'd2), next_rand(), 4'b1000, '0);
        issue(op_write, make_addr(10'h012, 4'd3, 2'd3), next_rand(), 4'b1111, '0);
        issue(op_write, make_addr(10'h012, 4'd3, 2'd0), next_rand(), 4'b1010, '0);
        issue(op_write, make_addr(10'h02a, 4'd3, 2'd2), next_rand(), 4'b1111, '0);
        for (int w = 0; w < words_per_line; w++) begin
            issue(op_read, make_addr(10'h012, 4'd3, 2'(w)), '0, '0, '0);
        end
        issue(op_read, make_addr(10'h02a, 4'd3, 2'd2), '0, '0, '0);
        end_test(3, "byte merge", e0);

        // Two ways per set, so the third fill lands back in way 0
        e0 = errors;
        issue(op_fill, make_addr(10'h040, 4'd5, 2'd0), '0, '0, rand_line());
        issue(op_fill, make_addr(10'h041, 4'd5, 2'd0), '0, '0, rand_line());
        issue(op_write, make_addr(10'h040, 4'd5, 2'd1), next_rand(), 4'b1111, '0);
        issue(op_fill, make_addr(10'h042, 4'd5, 2'd0), '0, '0, rand_line());
        issue(op_fill, make_addr(10'h043, 4'd5, 2'd0), '0, '0, rand_line());
        for (int t = 0; t < 4; t++) begin
            issue(op_read, make_addr(10'h040 + 10'(t), 4'd5, 2'd1), '0, '0, '0);
        end
        end_test(4, "round-robin eviction", e0);

        e0 = errors;
        issue(op_fill, make_addr(10'h070, 4'd7, 2'd0), '0, '0, rand_line());
        issue(op_write, make_addr(10'h070, 4'd7, 2'd2), next_rand(), 4'b0011, '0);
        issue(op_flush, make_addr(10'h070, 4'd7, 2'd2), '0, '0, '0);
        issue(op_flush, make_addr(10'h070, 4'd7, 2'd2), '0, '0, '0);
        issue(op_flush, make_addr(10'h071, 4'd7, 2'd0), '0, '0, '0);
        issue(op_read, make_addr(10'h070, 4'd7, 2'd2), '0, '0, '0);
        end_test(5, "flush", e0);

        // Two sets and four tags keep hits, evictions and same-set hazards frequent
        e0 = errors;
        for (int i = 0; i < num_rand; i++) begin
            rnd = next_rand();
            issue(cache_op_e'(rnd[1:0]), make_addr(10'h100 + 10'(rnd[3:2]), {3'b100, rnd[4]},
                  rnd[6:5]), next_rand(), rnd[10:7], rand_line());
        end
        end_test(6, "random traffic", e0);

        $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* cache_bank.sv */
// ==========================================================
// Cache bank top
// Tag lookup, data access and response stages in a chain
// ==========================================================
`timescale 1ns/1ps

module cache_bank (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  cache_pkg::cache_req_t   req,
    output logic                    rsp_valid,
    output cache_pkg::cache_rsp_t   rsp,
    output logic                    evict_valid,
    output cache_pkg::cache_evict_t evict
);
    import cache_pkg::*;

    logic         s1_valid;
    tag_result_t  s1;
    logic         s2_valid;
    data_result_t s2;

    cache_tag_stage i_tag_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .s1_valid  (s1_valid),
        .s1        (s1)
    );

    cache_data_stage i_data_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .s1_valid (s1_valid),
        .s1       (s1),
        .s2_valid (s2_valid),
        .s2       (s2)
    );

    cache_rsp_stage i_rsp_stage (
        .s2_valid    (s2_valid),
        .s2          (s2),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .evict_valid (evict_valid),
        .evict       (evict)
    );

endmodule

/* cache_rsp_stage.sv */
// ==========================================================
// Response stage
// Word select from the hit way, response and eviction outputs
// ==========================================================
`timescale 1ns/1ps

module cache_rsp_stage (
    input  logic                    s2_valid,
    input  cache_pkg::data_result_t s2,
    output logic                    rsp_valid,
    output cache_pkg::cache_rsp_t   rsp,
    output logic                    evict_valid,
    output cache_pkg::cache_evict_t evict
);
    import cache_pkg::*;

    logic [words_per_line-1:0][num_ways-1:0][word_width-1:0] transposed;
    logic [way_idx_bits-1:0] hit_idx;

    // Words first, ways last, so the way index can settle in parallel
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            for (int i = 0; i < words_per_line; i++) begin
                transposed[i][w] = s2.lines[w][i];
            end
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (s2.hit_mask[w]) begin
                hit_idx = w[way_idx_bits-1:0];
            end
        end
    end

    assign rsp_valid = s2_valid && (s2.op != op_fill);
    assign rsp.hit   = s2.hit;
    // Misses return zero
    assign rsp.data  = s2.hit ? transposed[s2.word_sel][hit_idx] : '0;

    assign evict_valid     = s2_valid && s2.evict;
    assign evict.line_addr = s2.evict_addr;
    assign evict.data      = s2.lines[s2.victim_idx];

endmodule

/* cache_data_stage.sv */
// ==========================================================
// Data access stage
// Line and dirty stores, fill install, byte merge on write hits
// and victim line readout for eviction
// ==========================================================
`timescale 1ns/1ps

module cache_data_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    s1_valid,
    input  cache_pkg::tag_result_t  s1,
    output logic                    s2_valid,
    output cache_pkg::data_result_t s2
);
    import cache_pkg::*;

    typedef line_t [num_ways-1:0]       way_lines_t;
    typedef logic [num_ways-1:0]        way_bits_t;
    typedef logic [num_ways-1:0][words_per_line-1:0][word_bytes-1:0] line_byteen_t;

    logic [set_sel_bits-1:0]   set_idx;
    logic [word_sel_bits-1:0]  word_sel;
    logic                      is_fill;
    logic                      write_en;
    logic                      fill_en;
    logic                      flush_en;
    logic [way_idx_bits-1:0]   victim_idx;
    line_byteen_t              data_wren;
    way_lines_t                data_wdata;
    way_lines_t                data_rdata;
    way_bits_t                 dirty_wren;
    way_bits_t                 dirty_wdata;
    way_bits_t                 dirty_rdata;
    // Set once a way's dirty bit has been written since reset
    logic [num_sets-1:0][num_ways-1:0] known_q;

    // Request meta held while the RAMs read
    logic                      m_valid;
    cache_op_e                 m_op;
    logic [word_sel_bits-1:0]  m_word_sel;
    logic [num_ways-1:0]       m_hit_mask;
    logic                      m_hit;
    logic [line_addr_bits-1:0] m_evict_addr;
    logic [way_idx_bits-1:0]   m_victim_idx;
    logic [num_ways-1:0]       m_known;
    logic                      line_dirty;

    assign set_idx  = s1.req.addr[word_sel_bits +: set_sel_bits];
    assign word_sel = s1.req.addr[word_sel_bits-1:0];
    assign is_fill  = (s1.req.op == op_fill);
    assign fill_en  = s1_valid && is_fill;
    assign write_en = s1_valid && (s1.req.op == op_write) && s1.hit;
    assign flush_en = s1_valid && (s1.req.op == op_flush) && s1.hit;

    always_comb begin
        victim_idx = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (s1.victim_way[w]) begin
                victim_idx = w[way_idx_bits-1:0];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            data_wdata[w] = is_fill ? s1.req.fill_line : {words_per_line{s1.req.wdata}};
        end
    end

    // Whole line of the victim way on a fill, selected bytes of one word on a write hit
    always_comb begin
        data_wren = '0;
        if (fill_en) begin
            data_wren[victim_idx] = '1;
        end else if (write_en) begin
            data_wren[victim_idx][word_sel] = s1.req.byteen;
        end
    end

    // Write hits set dirty, fills and flush hits clear it
    always_comb begin
        dirty_wren = '0;
        dirty_wren[victim_idx] = fill_en || write_en || flush_en;
    end

    assign dirty_wdata = {num_ways{write_en}};

    cache_sp_ram #(
        .data_t (way_lines_t),
        .lanes  (num_ways * words_per_line * word_bytes),
        .depth  (num_sets)
    ) i_data_store (
        .clk   (clk),
        .rst_n (rst_n),
        .read  (s1_valid),
        .write (fill_en || write_en),
        .wren  (data_wren),
        .addr  (set_idx),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    cache_sp_ram #(
        .data_t (way_bits_t),
        .lanes  (num_ways),
        .depth  (num_sets)
    ) i_dirty_store (
        .clk   (clk),
        .rst_n (rst_n),
        .read  (s1_valid),
        .write (|dirty_wren),
        .wren  (dirty_wren),
        .addr  (set_idx),
        .wdata (dirty_wdata),
        .rdata (dirty_rdata)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid  <= 1'b0;
            s2_valid <= 1'b0;
            known_q  <= '0;
        end else begin
            m_valid  <= s1_valid;
            s2_valid <= m_valid;
            if (|dirty_wren) begin
                known_q[set_idx] <= known_q[set_idx] | dirty_wren;
            end
        end
    end

    // Stale RAM contents never count as dirty
    assign line_dirty = m_known[m_victim_idx] && dirty_rdata[m_victim_idx];

    always_ff @(posedge clk) begin
        m_op          <= s1.req.op;
        m_word_sel    <= word_sel;
        m_hit_mask    <= s1.hit_mask;
        m_hit         <= s1.hit;
        m_evict_addr  <= {s1.victim_tag, set_idx};
        m_victim_idx  <= victim_idx;
        m_known       <= known_q[set_idx];
        s2.op         <= m_op;
        s2.word_sel   <= m_word_sel;
        s2.hit_mask   <= m_hit_mask;
        s2.hit        <= m_hit;
        s2.lines      <= data_rdata;
        s2.evict      <= line_dirty && (m_op == op_fill || (m_op == op_flush && m_hit));
        s2.evict_addr <= m_evict_addr;
        s2.victim_idx <= m_victim_idx;
    end

    wr_one_way_a: assert property (@(posedge clk) disable iff (!rst_n)
        (fill_en || write_en) |-> $onehot(s1.victim_way));

endmodule

/* cache_tag_stage.sv */
// ==========================================================
// Tag lookup stage
// Tag compare, hit mask, round-robin fill way and tag update
// ==========================================================
`timescale 1ns/1ps

module cache_tag_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  cache_pkg::cache_req_t  req,
    output logic                   s1_valid,
    output cache_pkg::tag_result_t s1
);
    import cache_pkg::*;

    // The whole tag array sits in one RAM word, so a lookup and a fill
    // update of another set can share the single port in the same cycle
    typedef tag_entry_t [num_sets-1:0][num_ways-1:0] tag_array_t;

    tag_array_t                            tag_rdata;
    tag_array_t                            tag_wdata;
    logic [num_sets-1:0][num_ways-1:0]     tag_wren;
    logic [num_sets-1:0][num_ways-1:0]     valid_q;
    logic [num_sets-1:0][way_idx_bits-1:0] rr_q;

    logic                      p0_valid;
    cache_req_t                p0_req;
    logic [set_sel_bits-1:0]   p0_set;
    logic [tag_bits-1:0]       p0_tag;
    logic                      wr_valid_q;
    logic [set_sel_bits-1:0]   wr_set_q;
    logic [way_idx_bits-1:0]   wr_way_q;
    tag_entry_t                wr_entry_q;
    tag_entry_t                new_entry;
    tag_entry_t [num_ways-1:0] entries;
    logic [num_ways-1:0]       hit_mask;
    logic                      hit;
    logic [way_idx_bits-1:0]   hit_idx;
    logic [way_idx_bits-1:0]   fill_idx;
    logic [way_idx_bits-1:0]   vict_idx;
    logic                      is_fill;
    logic                      tag_write;

    assign p0_set    = p0_req.addr[word_sel_bits +: set_sel_bits];
    assign p0_tag    = p0_req.addr[addr_width-1 -: tag_bits];
    assign new_entry = '{valid: 1'b1, tag: p0_tag};
    assign is_fill   = (p0_req.op == op_fill);
    assign tag_write = p0_valid && is_fill;

    // Patch in last cycle's write, which the read-first RAM missed
    always_comb begin
        entries = tag_rdata[p0_set];
        if (wr_valid_q && wr_set_q == p0_set) begin
            entries[wr_way_q] = wr_entry_q;
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_mask[w] = valid_q[p0_set][w] && entries[w].valid && (entries[w].tag == p0_tag);
            if (hit_mask[w]) begin
                hit_idx = w[way_idx_bits-1:0];
            end
        end
    end

    assign hit      = |hit_mask;
    assign fill_idx = hit ? hit_idx : rr_q[p0_set];
    assign vict_idx = is_fill ? fill_idx : hit_idx;

    always_comb begin
        tag_wren = '0;
        tag_wren[p0_set][fill_idx] = tag_write;
        tag_wdata = {(num_sets * num_ways){new_entry}};
    end

    cache_sp_ram #(
        .data_t (tag_array_t),
        .lanes  (num_sets * num_ways),
        .depth  (1)
    ) i_tag_store (
        .clk   (clk),
        .rst_n (rst_n),
        .read  (req_valid),
        .write (tag_write),
        .wren  (tag_wren),
        .addr  (1'b0),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p0_valid   <= 1'b0;
            s1_valid   <= 1'b0;
            wr_valid_q <= 1'b0;
            valid_q    <= '0;
            rr_q       <= '0;
        end else begin
            p0_valid   <= req_valid;
            s1_valid   <= p0_valid;
            wr_valid_q <= tag_write;
            if (tag_write) begin
                valid_q[p0_set][fill_idx] <= 1'b1;
                // A fill that hits keeps the pointer where it is
                if (!hit) begin
                    rr_q[p0_set] <= rr_q[p0_set] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        p0_req        <= req;
        wr_set_q      <= p0_set;
        wr_way_q      <= fill_idx;
        wr_entry_q    <= new_entry;
        s1.req        <= p0_req;
        s1.hit_mask   <= hit_mask;
        s1.hit        <= hit;
        s1.victim_way <= is_fill ? num_ways'(1) << fill_idx : hit_mask;
        s1.victim_tag <= entries[vict_idx].tag;
    end

    hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        p0_valid |-> $onehot0(hit_mask));

endmodule

/* cache_sp_ram.sv */
// ==========================================================
// Single-port read-first RAM
// Per-lane write enables, rdata registered one cycle after read
// ==========================================================
`timescale 1ns/1ps

module cache_sp_ram #(
    parameter type data_t = logic [31:0],
    parameter int  lanes  = 1,
    parameter int  depth  = 16
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       read,
    input  logic                                       write,
    input  logic [lanes-1:0]                           wren,
    input  logic [(depth > 1 ? $clog2(depth) : 1)-1:0] addr,
    input  data_t                                      wdata,
    output data_t                                      rdata
);
    localparam int lane_width = $bits(data_t) / lanes;

    typedef logic [lanes-1:0][lane_width-1:0] lane_vec_t;

    lane_vec_t mem [depth];
    lane_vec_t wvec;

    assign wvec = lane_vec_t'(wdata);

    // Old contents are sampled before the same-edge write lands
    always_ff @(posedge clk) begin
        if (read) begin
            rdata <= data_t'(mem[addr]);
        end
        if (write) begin
            for (int l = 0; l < lanes; l++) begin
                if (wren[l]) begin
                    mem[addr][l] <= wvec[l];
                end
            end
        end
    end

    addr_known_a: assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) |-> !$isunknown(addr));

endmodule

/* cache_pkg.sv */
// ==========================================================
// Cache bank package
// Geometry, operation codes and the structs that travel
// between the three pipeline stages of the bank
// ==========================================================
package cache_pkg;

    // Geometry
    localparam int num_ways       = 2;
    localparam int num_sets       = 16;
    localparam int words_per_line = 4;
    localparam int word_width     = 32;
    localparam int word_bytes     = 4;
    localparam int addr_width     = 16;

    // Word address split: tag | set | word
    localparam int word_sel_bits  = 2;
    localparam int set_sel_bits   = 4;
    localparam int tag_bits       = addr_width - set_sel_bits - word_sel_bits;
    localparam int way_idx_bits   = 1;
    localparam int line_addr_bits = addr_width - word_sel_bits;

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_fill  = 2'd2,
        op_flush = 2'd3
    } cache_op_e;

    typedef logic [words_per_line-1:0][word_width-1:0] line_t;

    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        cache_op_e                 op;
        logic [addr_width-1:0]     addr;
        logic [word_width-1:0]     wdata;
        logic [word_bytes-1:0]     byteen;
        line_t                     fill_line;
    } cache_req_t;

    typedef struct packed {
        cache_req_t          req;
        logic [num_ways-1:0] hit_mask;
        logic [num_ways-1:0] victim_way;
        logic                hit;
        logic [tag_bits-1:0] victim_tag;
    } tag_result_t;

    typedef struct packed {
        cache_op_e                 op;
        logic [word_sel_bits-1:0]  word_sel;
        logic [num_ways-1:0]       hit_mask;
        logic                      hit;
        line_t [num_ways-1:0]      lines;
        logic                      evict;
        logic [line_addr_bits-1:0] evict_addr;
        logic [way_idx_bits-1:0]   victim_idx;
    } data_result_t;

    typedef struct packed {
        logic [word_width-1:0] data;
        logic                  hit;
    } cache_rsp_t;

    typedef struct packed {
        logic [line_addr_bits-1:0] line_addr;
        line_t                     data;
    } cache_evict_t;

endpackage
